// ==== rtl/ahb_accel_pkg.sv ====
// AHB accelerator shared definitions
`default_nettype none

package ahb_accel_pkg;

  typedef logic [31:0] word_t;

  // AHB transfer type
  typedef enum logic [1:0] {
    TRN_IDLE   = 2'b00,
    TRN_BUSY   = 2'b01,
    TRN_NONSEQ = 2'b10,
    TRN_SEQ    = 2'b11
  } htrans_t;

  // AHB response
  typedef enum logic [1:0] {
    RSP_OKAY  = 2'b00,
    RSP_ERROR = 2'b01,
    RSP_RETRY = 2'b10,
    RSP_SPLIT = 2'b11
  } hresp_t;

  // Only the bursts the master issues
  typedef enum logic [2:0] {
    BURST_SINGLE = 3'b000,
    BURST_INCR8  = 3'b101,
    BURST_INCR16 = 3'b111
  } hburst_t;

  localparam logic [2:0] HSIZE_WORD = 3'b010;
  localparam logic [3:0] HPROT_DATA = 4'b0001;  // Data access, user, non-bufferable

  typedef enum logic [3:0] {
    ST_IDLE    = 4'd0,
    ST_WAIT    = 4'd1,
    ST_COEF_RD = 4'd2,
    ST_DATA_RD = 4'd3,
    ST_RD_END  = 4'd4,
    ST_OUT_WR  = 4'd5,
    ST_WR_END  = 4'd6
  } dma_state_t;

  // Status code seen by the host
  typedef enum logic [3:0] {
    STAT_VALID  = 4'b0000,
    STAT_WAIT   = 4'b0010,
    STAT_INPUT  = 4'b0100,
    STAT_OUTPUT = 4'b1000
  } status_t;

  // Register offsets, low 16 address bits
  localparam logic [15:0] REG_START     = 16'h0000;
  localparam logic [15:0] REG_STATUS    = 16'h0004;
  localparam logic [15:0] REG_DEST      = 16'h0008;
  localparam logic [15:0] REG_COEF_SRC  = 16'h000C;
  localparam logic [15:0] REG_DATA_SRC  = 16'h0010;
  localparam logic [15:0] REG_BLK_COUNT = 16'h0014;
  localparam logic [15:0] REG_RESP      = 16'h0018;

  localparam word_t UNMAPPED_RDATA = 32'h0000_AAAA;

  localparam integer BLK_WORDS      = 8;
  localparam integer BYTES_PER_WORD = 4;

endpackage

`default_nettype wire

// ==== rtl/ahb_reg_slave.sv ====
// AHB register slave
`timescale 1ns/1ps
`default_nettype none

module ahb_reg_slave
  import ahb_accel_pkg::*;
(
  input  logic       HCLK,
  input  logic       HRESETn,
  input  word_t      s_haddr_i,
  input  htrans_t    s_htrans_i,
  input  logic       s_hwrite_i,
  input  word_t      s_hwdata_i,
  input  logic       s_hsel_i,
  input  logic       s_hready_i,
  output word_t      s_hrdata_o,
  output logic       s_hreadyout_o,
  output hresp_t     s_hresp_o,
  input  dma_state_t state_i,
  input  logic       out_err_i,
  output logic       start_o,
  output word_t      dest_addr_o,
  output word_t      coef_src_o,
  output word_t      data_src_o,
  output word_t      blk_count_o
);

  logic        addr_valid;
  logic        valid_q;      // Data phase of a valid transfer
  logic        write_q;
  logic [15:0] addr_q;
  logic        wr_act;
  logic        rd_act;
  logic        start_q;
  logic        resp_q;
  status_t     status_q;
  word_t       dest_q;
  word_t       coef_src_q;
  word_t       data_src_q;
  word_t       blk_count_q;

  assign addr_valid = s_hsel_i && s_hready_i && s_htrans_i[1];
  assign wr_act     = valid_q && write_q;
  assign rd_act     = valid_q && !write_q;

  ////////////////////////////////////////////////////////////
  // Address phase capture
  ////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      valid_q       <= 1'b0;
      write_q       <= 1'b0;
      addr_q        <= '0;
      s_hreadyout_o <= 1'b0;
    end
    else
    begin
      valid_q       <= addr_valid;
      s_hreadyout_o <= 1'b1;       // Zero-wait from the first clock
      if (addr_valid)
      begin
        write_q <= s_hwrite_i;
        addr_q  <= s_haddr_i[15:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Register writes, status and error flag
  ////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      start_q     <= 1'b0;
      resp_q      <= 1'b0;
      status_q    <= STAT_VALID;
      dest_q      <= '0;
      coef_src_q  <= '0;
      data_src_q  <= '0;
      blk_count_q <= '0;
    end
    else
    begin
      start_q <= wr_act && (addr_q == REG_START) && s_hwdata_i[0];  // One-cycle pulse
      if (wr_act)
      begin
        case (addr_q)
          REG_DEST:      dest_q      <= s_hwdata_i;
          REG_COEF_SRC:  coef_src_q  <= s_hwdata_i;
          REG_DATA_SRC:  data_src_q  <= s_hwdata_i;
          REG_BLK_COUNT: blk_count_q <= s_hwdata_i;
          default:       ;
        endcase
      end

      // Sticky until the next job starts
      if (start_q)
        resp_q <= 1'b0;
      else if (out_err_i)
        resp_q <= 1'b1;

      case (state_i)
        ST_WAIT:                           status_q <= STAT_WAIT;
        ST_COEF_RD, ST_DATA_RD, ST_RD_END: status_q <= STAT_INPUT;
        ST_OUT_WR, ST_WR_END:              status_q <= STAT_OUTPUT;
        default:                           status_q <= STAT_VALID;
      endcase
    end
  end

  // Read data in the data phase
  always_comb
  begin
    s_hrdata_o = '0;
    if (rd_act)
    begin
      case (addr_q)
        REG_START:     s_hrdata_o = {31'd0, start_q};
        REG_STATUS:    s_hrdata_o = {28'd0, status_q};
        REG_DEST:      s_hrdata_o = dest_q;
        REG_COEF_SRC:  s_hrdata_o = coef_src_q;
        REG_DATA_SRC:  s_hrdata_o = data_src_q;
        REG_BLK_COUNT: s_hrdata_o = blk_count_q;
        REG_RESP:      s_hrdata_o = {31'd0, resp_q};
        default:       s_hrdata_o = UNMAPPED_RDATA;
      endcase
    end
  end

  assign s_hresp_o   = RSP_OKAY;
  assign start_o     = start_q;
  assign dest_addr_o = dest_q;
  assign coef_src_o  = coef_src_q;
  assign data_src_o  = data_src_q;
  assign blk_count_o = blk_count_q;

endmodule

`default_nettype wire

// ==== rtl/ahb_burst_master.sv ====
// AHB burst master
`timescale 1ns/1ps
`default_nettype none

module ahb_burst_master
  import ahb_accel_pkg::*;
#(
  parameter integer COEF_WORDS = 16
)
(
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic                          m_hready_i,
  input  logic                          m_hgrant_i,
  input  hresp_t                        m_hresp_i,
  output logic                          m_hbusreq_o,
  output logic                          m_hlock_o,
  output htrans_t                       m_htrans_o,
  output word_t                         m_haddr_o,
  output logic                          m_hwrite_o,
  output logic [2:0]                    m_hsize_o,
  output hburst_t                       m_hburst_o,
  output logic [3:0]                    m_hprot_o,
  output word_t                         m_hwdata_o,
  input  word_t                         dest_addr_i,
  input  word_t                         coef_src_i,
  input  word_t                         data_src_i,
  input  logic                          need_coef_i,
  input  logic                          need_data_i,
  input  logic                          need_out_i,
  input  logic                          finish_i,
  input  word_t                         blk_idx_i,
  input  word_t                         res_word_i,
  output logic                          wr_en_o,
  output logic [$clog2(COEF_WORDS)-1:0] wr_beat_o,
  output logic [$clog2(BLK_WORDS)-1:0]  rd_beat_o,
  output logic                          block_done_o,
  output dma_state_t                    state_o,
  output logic                          out_err_o
);

  localparam integer BEAT_W = $clog2(COEF_WORDS);
  localparam integer BLK_W  = $clog2(BLK_WORDS);
  // INCR16 for the default 16-entry table
  localparam hburst_t COEF_BURST = (COEF_WORDS == BLK_WORDS) ? BURST_INCR8 : BURST_INCR16;

  dma_state_t        state_q, state_d;
  logic [BEAT_W-1:0] beat_q, beat_d;
  logic [BEAT_W-1:0] last_beat;
  logic [BEAT_W-1:0] dp_beat_q;
  logic              dp_rd_q;    // Read beat in its data phase
  logic              dp_wr_q;    // Write beat in its data phase
  logic              go;
  logic              in_burst;
  word_t             blk_off;
  word_t             base;

  assign go        = m_hready_i && m_hgrant_i;
  assign in_burst  = (state_q == ST_COEF_RD) || (state_q == ST_DATA_RD) ||
                     (state_q == ST_OUT_WR);
  assign last_beat = (state_q == ST_COEF_RD) ? BEAT_W'(COEF_WORDS - 1) : BEAT_W'(BLK_WORDS - 1);

  ////////////////////////////////////////////////////////////
  // Next state and beat counter
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    state_d = state_q;
    beat_d  = beat_q;
    case (state_q)
      ST_IDLE:
        if (need_coef_i || need_data_i || need_out_i)
          state_d = ST_WAIT;
      ST_WAIT:
        if (go)
        begin
          if (finish_i)
            state_d = ST_IDLE;
          else if (need_out_i)
            state_d = ST_OUT_WR;
          else if (need_coef_i)
            state_d = ST_COEF_RD;
          else if (need_data_i)
            state_d = ST_DATA_RD;
        end
      ST_COEF_RD, ST_DATA_RD, ST_OUT_WR:
        if (go)
        begin
          if (beat_q == last_beat)
          begin
            beat_d  = '0;
            state_d = (state_q == ST_OUT_WR) ? ST_WR_END : ST_RD_END;
          end
          else
            beat_d = beat_q + 1'b1;
        end
      ST_RD_END, ST_WR_END:
        if (go)
          state_d = ST_WAIT;   // Last data phase done
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state_q   <= ST_IDLE;
      beat_q    <= '0;
      dp_rd_q   <= 1'b0;
      dp_wr_q   <= 1'b0;
      dp_beat_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      beat_q  <= beat_d;
      if (go)
      begin
        dp_rd_q   <= (state_q == ST_COEF_RD) || (state_q == ST_DATA_RD);
        dp_wr_q   <= state_q == ST_OUT_WR;
        dp_beat_q <= beat_q;
      end
    end
  end

  // Write data follows its address by one go-cycle
  always_ff @(posedge HCLK)
  begin
    if (go)
      m_hwdata_o <= res_word_i;
  end

  ////////////////////////////////////////////////////////////
  // Bus-side control
  ////////////////////////////////////////////////////////////
  assign blk_off = blk_idx_i * BLK_WORDS * BYTES_PER_WORD;

  always_comb
  begin
    case (state_q)
      ST_COEF_RD: base = coef_src_i;
      ST_DATA_RD: base = data_src_i + blk_off;
      default:    base = dest_addr_i + blk_off;
    endcase
  end

  assign m_hbusreq_o = state_q != ST_IDLE;
  assign m_hlock_o   = state_q != ST_IDLE;
  assign m_htrans_o  = !in_burst ? TRN_IDLE : ((beat_q == '0) ? TRN_NONSEQ : TRN_SEQ);
  assign m_haddr_o   = in_burst ? base + word_t'(beat_q) * BYTES_PER_WORD : '0;
  assign m_hwrite_o  = state_q == ST_OUT_WR;
  assign m_hsize_o   = HSIZE_WORD;
  assign m_hprot_o   = HPROT_DATA;

  always_comb
  begin
    case (state_q)
      ST_COEF_RD:           m_hburst_o = COEF_BURST;
      ST_DATA_RD, ST_OUT_WR: m_hburst_o = BURST_INCR8;
      default:              m_hburst_o = BURST_SINGLE;
    endcase
  end

  // Engine side
  assign wr_en_o      = dp_rd_q && go;
  assign wr_beat_o    = dp_beat_q;
  assign rd_beat_o    = beat_q[BLK_W-1:0];  // Result word for the address phase
  assign block_done_o = (state_q == ST_WR_END) && go;
  assign state_o      = state_q;
  assign out_err_o    = dp_wr_q && (m_hresp_i != RSP_OKAY);

endmodule

`default_nettype wire

// ==== rtl/blk_engine.sv ====
// Block transform engine
`timescale 1ns/1ps
`default_nettype none

module blk_engine
  import ahb_accel_pkg::*;
#(
  parameter integer COEF_WORDS = 16
)
(
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic                          start_i,
  input  word_t                         blk_count_i,
  input  logic                          wr_en_i,
  input  logic [$clog2(COEF_WORDS)-1:0] wr_beat_i,
  input  logic [$clog2(BLK_WORDS)-1:0]  rd_beat_i,
  input  logic                          block_done_i,
  input  word_t                         rdata_i,
  output logic                          need_coef_o,
  output logic                          need_data_o,
  output logic                          need_out_o,
  output logic                          finish_o,
  output word_t                         blk_idx_o,
  output word_t                         res_word_o
);

  localparam integer BEAT_W = $clog2(COEF_WORDS);
  localparam integer BLK_W  = $clog2(BLK_WORDS);

  word_t             coef_mem [COEF_WORDS];
  word_t             blk_buf  [BLK_WORDS];
  logic              job_q;      // A job has been started
  logic              coef_ok_q;
  logic              data_ok_q;
  word_t             blk_idx_q;
  logic              coef_last;
  logic              data_last;
  word_t             coef_pos;
  logic [BEAT_W-1:0] coef_idx;

  // Read data goes to the table until it is full
  assign coef_last = wr_en_i && !coef_ok_q && (wr_beat_i == BEAT_W'(COEF_WORDS - 1));
  assign data_last = wr_en_i && coef_ok_q && (wr_beat_i == BEAT_W'(BLK_WORDS - 1));

  ////////////////////////////////////////////////////////////
  // Buffers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK)
  begin
    if (wr_en_i)
    begin
      if (!coef_ok_q)
        coef_mem[wr_beat_i] <= rdata_i;
      else
        blk_buf[wr_beat_i[BLK_W-1:0]] <= rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Job tracking
  ////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      job_q     <= 1'b0;
      coef_ok_q <= 1'b0;
      data_ok_q <= 1'b0;
      blk_idx_q <= '0;
    end
    else if (start_i)
    begin
      job_q     <= 1'b1;
      coef_ok_q <= 1'b0;
      data_ok_q <= 1'b0;
      blk_idx_q <= '0;
    end
    else
    begin
      if (coef_last)
        coef_ok_q <= 1'b1;
      if (data_last)
        data_ok_q <= 1'b1;
      if (block_done_i)
      begin
        data_ok_q <= 1'b0;              // Buffer free for the next block
        blk_idx_q <= blk_idx_q + 1'b1;
      end
    end
  end

  assign finish_o    = job_q && coef_ok_q && !data_ok_q && (blk_idx_q == blk_count_i);
  assign need_coef_o = job_q && !coef_ok_q;
  assign need_data_o = job_q && coef_ok_q && !data_ok_q && !finish_o;
  assign need_out_o  = job_q && data_ok_q;
  assign blk_idx_o   = blk_idx_q;

  // Coefficient index wraps over the table
  assign coef_pos   = blk_idx_q * BLK_WORDS + word_t'(rd_beat_i);
  assign coef_idx   = coef_pos[BEAT_W-1:0];
  assign res_word_o = blk_buf[rd_beat_i] + coef_mem[coef_idx];

endmodule

`default_nettype wire

// ==== rtl/ahb_blk_accel.sv ====
// AHB block accelerator top
`timescale 1ns/1ps
`default_nettype none

module ahb_blk_accel
  import ahb_accel_pkg::*;
#(
  parameter integer COEF_WORDS = 16
)
(
  input  logic       HCLK,
  input  logic       HRESETn,
  // Host slave port
  input  word_t      s_haddr_i,
  input  htrans_t    s_htrans_i,
  input  logic       s_hwrite_i,
  input  word_t      s_hwdata_i,
  input  logic       s_hsel_i,
  input  logic       s_hready_i,
  output word_t      s_hrdata_o,
  output logic       s_hreadyout_o,
  output hresp_t     s_hresp_o,
  // Memory master port
  input  logic       m_hready_i,
  input  hresp_t     m_hresp_i,
  input  word_t      m_hrdata_i,
  input  logic       m_hgrant_i,
  output logic       m_hbusreq_o,
  output logic       m_hlock_o,
  output htrans_t    m_htrans_o,
  output word_t      m_haddr_o,
  output logic       m_hwrite_o,
  output logic [2:0] m_hsize_o,
  output hburst_t    m_hburst_o,
  output logic [3:0] m_hprot_o,
  output word_t      m_hwdata_o
);

  logic                          start;
  word_t                         dest_addr, coef_src, data_src, blk_count;
  dma_state_t                    state;
  logic                          out_err;
  logic                          need_coef, need_data, need_out, finish;
  word_t                         blk_idx, res_word;
  logic                          wr_en, block_done;
  logic [$clog2(COEF_WORDS)-1:0] wr_beat;
  logic [$clog2(BLK_WORDS)-1:0]  rd_beat;

  ahb_reg_slave u_reg_slave (
    .HCLK, .HRESETn,
    .s_haddr_i, .s_htrans_i, .s_hwrite_i, .s_hwdata_i, .s_hsel_i, .s_hready_i,
    .s_hrdata_o, .s_hreadyout_o, .s_hresp_o,
    .state_i (state),           .out_err_i  (out_err),
    .start_o (start),           .dest_addr_o (dest_addr),
    .coef_src_o (coef_src),     .data_src_o (data_src),
    .blk_count_o (blk_count)
  );

  ahb_burst_master #(.COEF_WORDS(COEF_WORDS)) u_burst_master (
    .HCLK, .HRESETn,
    .m_hready_i, .m_hgrant_i, .m_hresp_i,
    .m_hbusreq_o, .m_hlock_o, .m_htrans_o, .m_haddr_o, .m_hwrite_o,
    .m_hsize_o, .m_hburst_o, .m_hprot_o, .m_hwdata_o,
    .dest_addr_i (dest_addr),   .coef_src_i (coef_src),
    .data_src_i (data_src),     .need_coef_i (need_coef),
    .need_data_i (need_data),   .need_out_i (need_out),
    .finish_i (finish),         .blk_idx_i (blk_idx),
    .res_word_i (res_word),     .wr_en_o (wr_en),
    .wr_beat_o (wr_beat),       .rd_beat_o (rd_beat),
    .block_done_o (block_done), .state_o (state),
    .out_err_o (out_err)
  );

  blk_engine #(.COEF_WORDS(COEF_WORDS)) u_blk_engine (
    .HCLK, .HRESETn,
    .start_i (start),           .blk_count_i (blk_count),
    .wr_en_i (wr_en),           .wr_beat_i (wr_beat),
    .rd_beat_i (rd_beat),       .block_done_i (block_done),
    .rdata_i (m_hrdata_i),      .need_coef_o (need_coef),
    .need_data_o (need_data),   .need_out_o (need_out),
    .finish_o (finish),         .blk_idx_o (blk_idx),
    .res_word_o (res_word)
  );

endmodule

`default_nettype wire

// ==== tests/tb_ahb_blk_accel.sv ====
// AHB block accelerator testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_blk_accel
  import ahb_accel_pkg::*;
();

  localparam integer COEF_WORDS  = 16;
  localparam integer MEM_WORDS   = 256;
  localparam integer MAX_POLLS   = 300;
  // Five jobs bounded by their status polls, plus the register test
  localparam integer CYCLE_LIMIT = 5 * (2 * MAX_POLLS + 20) + 200;

  logic       HCLK = 1'b0;
  logic       HRESETn;
  word_t      s_haddr_i;
  htrans_t    s_htrans_i;
  logic       s_hwrite_i;
  word_t      s_hwdata_i;
  logic       s_hsel_i;
  logic       s_hready_i;
  word_t      s_hrdata_o;
  logic       s_hreadyout_o;
  hresp_t     s_hresp_o;
  logic       m_hready_i;
  hresp_t     m_hresp_i;
  word_t      m_hrdata_i;
  logic       m_hgrant_i;
  logic       m_hbusreq_o;
  logic       m_hlock_o;
  htrans_t    m_htrans_o;
  word_t      m_haddr_o;
  logic       m_hwrite_o;
  logic [2:0] m_hsize_o;
  hburst_t    m_hburst_o;
  logic [3:0] m_hprot_o;
  word_t      m_hwdata_o;

  word_t mem [MEM_WORDS];     // Memory behind the master port
  word_t exp_res [64];
  int    err_count   = 0;
  int    check_count = 0;
  int    test_count  = 0;
  int    cycle_count = 0;

  // Memory model controls
  logic  wait_en    = 1'b0;   // LFSR wait states
  int    err_beat   = -1;     // Write beat that gets ERROR
  int    hold_after = -1;     // Address beat after which grant drops
  int    hold_len   = 0;
  int    wr_beats   = 0;
  int    addr_beats = 0;
  word_t coef_base  = '0;     // Coefficient table of the current job

  ahb_blk_accel #(.COEF_WORDS(COEF_WORDS)) u_ahb_blk_accel (.*);

  initial
  begin
    forever #5 HCLK = ~HCLK;
  end

  always @(posedge HCLK)
  begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers and compare tasks
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic word_t fill_word(input int unsigned idx);
    fill_word = (idx * 32'h9E37_79B1) ^ (idx << 20) ^ 32'h5A3C_0F1E;
  endfunction

  function automatic int mem_index(input word_t addr);
    mem_index = int'(addr[9:2]);
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("mismatch at %0t: %s, expected %h, got %h", $time, what, exp, got);
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("mismatch at %0t: %s, expected %h, got %h", $time, what, exp, got);
    end
  endtask

  task automatic check_trans(input htrans_t got, input htrans_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("mismatch at %0t: %s, expected %h, got %h", $time, what, exp, got);
    end
  endtask

  task automatic check_resp(input hresp_t got, input hresp_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("mismatch at %0t: %s, expected %h, got %h", $time, what, exp, got);
    end
  endtask

  task automatic check_burst(input hburst_t got, input hburst_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("mismatch at %0t: %s, expected %h, got %h", $time, what, exp, got);
    end
  endtask

  task automatic note_failure(input string what);
    err_count++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before)
      $display("test %s: ok", name);
    else
      $display("test %s: FAIL with %0d errors", name, err_count - errs_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Memory and arbiter model
  ////////////////////////////////////////////////////////////
  initial
  begin : mem_model
    logic [31:0] lfsr;
    logic        rdy, gnt, go_now, active;
    logic        stall_prev, held_wr, pend_vld, pend_wr, b0, b1;
    word_t       pend_addr, held_addr, held_wdata;
    htrans_t     held_trans;
    int          hold_cnt;
    lfsr       = 32'h3cdf;
    stall_prev = 1'b0;
    pend_vld   = 1'b0;
    hold_cnt   = 0;
    m_hready_i = 1'b1;
    m_hgrant_i = 1'b1;
    m_hresp_i  = RSP_OKAY;
    m_hrdata_i = '0;
    forever
    begin
      @(negedge HCLK);
      if (!HRESETn)
      begin
        pend_vld   = 1'b0;
        stall_prev = 1'b0;
      end
      else
      begin
        rdy = 1'b1;
        if (wait_en)
        begin
          lfsr = lfsr_next(lfsr);
          b0   = lfsr[0];
          lfsr = lfsr_next(lfsr);
          b1   = lfsr[0];
          rdy  = !(b0 && b1);     // About one cycle in four
        end
        gnt = (hold_cnt == 0);
        if (hold_cnt > 0)
          hold_cnt--;
        go_now = rdy && gnt;
        active = (m_htrans_o == TRN_NONSEQ) || (m_htrans_o == TRN_SEQ);

        // Transfer attributes of every address beat
        if (active)
        begin
          check_word(word_t'(m_hsize_o), word_t'(HSIZE_WORD), "HSIZE of a bus beat");
          check_word(word_t'(m_hprot_o), word_t'(HPROT_DATA), "HPROT of a bus beat");
          if (!m_hwrite_o && m_haddr_o >= coef_base &&
              m_haddr_o < coef_base + COEF_WORDS * BYTES_PER_WORD)
            check_burst(m_hburst_o, BURST_INCR16, "coefficient burst type");
          else
            check_burst(m_hburst_o, BURST_INCR8, "block burst type");
        end

        if (stall_prev)
        begin
          check_word(m_haddr_o, held_addr, "address under back-pressure");
          check_trans(m_htrans_o, held_trans, "HTRANS under back-pressure");
          if (held_wr)
            check_word(m_hwdata_o, held_wdata, "write data under back-pressure");
        end

        // Data phase of the pending beat
        m_hrdata_i = (pend_vld && !pend_wr) ? mem[mem_index(pend_addr)] : '0;
        m_hresp_i  = RSP_OKAY;
        if (pend_vld && pend_wr && go_now)
        begin
          mem[mem_index(pend_addr)] = m_hwdata_o;
          if (wr_beats == err_beat)
            m_hresp_i = RSP_ERROR;
          wr_beats++;
        end

        stall_prev = active && !go_now;
        held_addr  = m_haddr_o;
        held_trans = m_htrans_o;
        held_wdata = m_hwdata_o;
        held_wr    = pend_vld && pend_wr;
        if (go_now)
        begin
          pend_vld  = active;
          pend_wr   = m_hwrite_o;
          pend_addr = m_haddr_o;
          if (active)
          begin
            addr_beats++;
            if (addr_beats == hold_after)
              hold_cnt = hold_len;
          end
        end
        m_hready_i = rdy;
        m_hgrant_i = gnt;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Host bus and job tasks
  ////////////////////////////////////////////////////////////
  task automatic host_write(input logic [15:0] off, input word_t data);
    s_haddr_i  = {16'h4000, off};
    s_htrans_i = TRN_NONSEQ;
    s_hwrite_i = 1'b1;
    s_hsel_i   = 1'b1;
    @(negedge HCLK);
    s_htrans_i = TRN_IDLE;
    s_hwrite_i = 1'b0;
    s_hsel_i   = 1'b0;
    s_hwdata_i = data;              // Data phase
    @(negedge HCLK);
  endtask

  task automatic host_read(input logic [15:0] off, output word_t data);
    s_haddr_i  = {16'h4000, off};
    s_htrans_i = TRN_NONSEQ;
    s_hwrite_i = 1'b0;
    s_hsel_i   = 1'b1;
    @(negedge HCLK);
    s_htrans_i = TRN_IDLE;
    s_hsel_i   = 1'b0;
    data       = s_hrdata_o;
    check_resp(s_hresp_o, RSP_OKAY, "slave HRESP in a read data phase");
  endtask

  task automatic start_job(input word_t coef, input word_t data, input word_t dest,
                           input int nblk);
    int k;
    int waited;
    // Word k of the job is block k/8, word k%8, coefficient k mod 16
    for (k = 0; k < nblk * BLK_WORDS; k++)
    begin
      exp_res[k] = mem[mem_index(data) + k] + mem[mem_index(coef) + (k % COEF_WORDS)];
      mem[mem_index(dest) + k] = ~fill_word(mem_index(dest) + k);
    end
    wr_beats   = 0;
    addr_beats = 0;
    coef_base  = coef;
    host_write(REG_DEST, dest);
    host_write(REG_COEF_SRC, coef);
    host_write(REG_DATA_SRC, data);
    host_write(REG_BLK_COUNT, word_t'(nblk));
    host_write(REG_START, 32'd1);
    waited = 0;
    while (!m_hbusreq_o && waited < 2)
    begin
      @(negedge HCLK);
      waited++;
    end
    if (!m_hbusreq_o)
      note_failure("bus request did not rise within 2 cycles of the start write");
  endtask

  task automatic finish_job(input word_t dest, input int nblk, input string name);
    int      polls;
    int      k;
    word_t   rd;
    status_t st;
    polls = 0;
    host_read(REG_STATUS, rd);
    st = status_t'(rd[3:0]);
    while (st != STAT_VALID && polls < MAX_POLLS)
    begin
      if (st != STAT_WAIT && st != STAT_INPUT && st != STAT_OUTPUT)
        note_failure("status register holds an unknown code during the job");
      host_read(REG_STATUS, rd);
      st = status_t'(rd[3:0]);
      polls++;
    end
    if (st != STAT_VALID)
      note_failure("job did not finish within the status poll limit");
    // Status must not show VALID before every result is out
    check_word(word_t'(wr_beats), word_t'(nblk * BLK_WORDS), "write beats at VALID");
    for (k = 0; k < nblk * BLK_WORDS; k++)
      check_word(mem[mem_index(dest) + k], exp_res[k],
                 $sformatf("%s result word %0d", name, k));
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic test_reset_regs();
    int    e0;
    word_t rd;
    e0 = err_count;
    HRESETn = 1'b0;
    @(negedge HCLK);
    check_word({31'd0, s_hreadyout_o}, 32'd0, "HREADYOUT in reset");
    @(negedge HCLK);
    HRESETn = 1'b1;
    @(negedge HCLK);
    check_word({31'd0, s_hreadyout_o}, 32'd1, "HREADYOUT after reset");
    check_word({31'd0, m_hbusreq_o}, 32'd0, "HBUSREQ after reset");
    check_word({31'd0, m_hlock_o}, 32'd0, "HLOCK after reset");
    check_trans(m_htrans_o, TRN_IDLE, "master HTRANS after reset");
    host_write(REG_DEST, 32'h1357_9BDF);
    host_write(REG_COEF_SRC, 32'h2468_ACE0);
    host_write(REG_DATA_SRC, 32'hF0E1_D2C3);
    host_write(REG_BLK_COUNT, 32'h0000_0005);
    host_read(REG_DEST, rd);
    check_word(rd, 32'h1357_9BDF, "DEST readback");
    host_read(REG_COEF_SRC, rd);
    check_word(rd, 32'h2468_ACE0, "COEF_SRC readback");
    host_read(REG_DATA_SRC, rd);
    check_word(rd, 32'hF0E1_D2C3, "DATA_SRC readback");
    host_read(REG_BLK_COUNT, rd);
    check_word(rd, 32'h0000_0005, "BLK_COUNT readback");
    host_read(16'h001C, rd);
    check_word(rd, UNMAPPED_RDATA, "unmapped offset 0x1c");
    host_read(16'h0400, rd);
    check_word(rd, UNMAPPED_RDATA, "unmapped offset 0x400");
    host_read(REG_STATUS, rd);
    check_status(status_t'(rd[3:0]), STAT_VALID, "idle status");
    report_test("reset and register access", e0);
  endtask

  task automatic test_one_block();
    int e0;
    e0 = err_count;
    start_job(32'h100, 32'h200, 32'h300, 1);
    finish_job(32'h300, 1, "one block");
    report_test("one block", e0);
  endtask

  task automatic test_three_blocks_waits();
    int e0;
    e0 = err_count;
    wait_en = 1'b1;
    start_job(32'h140, 32'h240, 32'h340, 3);   // Third block wraps the table
    finish_job(32'h340, 3, "three blocks");
    wait_en = 1'b0;
    report_test("three blocks with wait states", e0);
  endtask

  task automatic test_grant_stall();
    int e0;
    e0 = err_count;
    hold_after = 10;                           // Mid coefficient burst
    hold_len   = 12;
    start_job(32'h100, 32'h280, 32'h3A0, 2);
    finish_job(32'h3A0, 2, "grant stall");
    hold_after = -1;
    report_test("grant withheld mid-burst", e0);
  endtask

  task automatic test_error_resp();
    int    e0;
    word_t rd;
    e0 = err_count;
    err_beat = 3;
    start_job(32'h100, 32'h200, 32'h300, 1);
    finish_job(32'h300, 1, "error job");
    host_read(REG_RESP, rd);
    check_word(rd, 32'd1, "RESP after ERROR on an output beat");
    err_beat = -1;
    start_job(32'h140, 32'h2C0, 32'h320, 1);
    host_read(REG_RESP, rd);
    check_word(rd, 32'd0, "RESP after the next start");
    finish_job(32'h320, 1, "clean job");
    report_test("error response flag", e0);
  endtask

  initial
  begin : main
    int i;
    HRESETn    = 1'b0;
    s_haddr_i  = '0;
    s_htrans_i = TRN_IDLE;
    s_hwrite_i = 1'b0;
    s_hwdata_i = '0;
    s_hsel_i   = 1'b0;
    s_hready_i = 1'b1;
    for (i = 0; i < MEM_WORDS; i++)
      mem[i] = fill_word(i);
    test_reset_regs();
    test_one_block();
    test_three_blocks_waits();
    test_grant_stall();
    test_error_resp();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ahb_blk_accel.f ====
rtl/ahb_accel_pkg.sv
rtl/ahb_reg_slave.sv
rtl/ahb_burst_master.sv
rtl/blk_engine.sv
rtl/ahb_blk_accel.sv
tests/tb_ahb_blk_accel.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' ahb_blk_accel.f)

.PHONY: run clean

run: obj_dir/Vtb_ahb_blk_accel
	@out=$$(./obj_dir/Vtb_ahb_blk_accel); echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

obj_dir/Vtb_ahb_blk_accel: ahb_blk_accel.f $(SRCS)
	verilator --binary --timing --top-module tb_ahb_blk_accel \
	  -f ahb_blk_accel.f -o Vtb_ahb_blk_accel

clean:
	rm -rf obj_dir
